//--- hdmi_timing_pkg.sv
package hdmi_timing_pkg;

	//////////////////////////////////////////////////
	// Small video mode, sized for fast simulation
	//////////////////////////////////////////////////

	// Horizontal, in pixel slots
	localparam int H_ACTIVE = 16;
	localparam int H_FRONT  = 4;
	localparam int H_SYNC   = 4;
	localparam int H_BACK   = 14;
	localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;

	// Vertical, in lines
	localparam int V_ACTIVE = 4;
	localparam int V_FRONT  = 1;
	localparam int V_SYNC   = 2;
	localparam int V_BACK   = 2;
	localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

	// Video preamble and leading guard band, at the end of the back porch
	localparam int PREAMBLE_LEN = 8;
	localparam int GUARD_LEN    = 2;

	// Counter widths
	localparam int H_CNT_W = $clog2(H_TOTAL);
	localparam int V_CNT_W = $clog2(V_TOTAL);

	// Sync windows, first slot and first slot after
	localparam int H_SYNC_START = H_ACTIVE + H_FRONT;
	localparam int H_SYNC_END   = H_SYNC_START + H_SYNC;
	localparam int V_SYNC_START = V_ACTIVE + V_FRONT;
	localparam int V_SYNC_END   = V_SYNC_START + V_SYNC;

	// First preamble slot and first guard slot
	localparam int H_GUARD_START    = H_TOTAL - GUARD_LEN;
	localparam int H_PREAMBLE_START = H_GUARD_START - PREAMBLE_LEN;

	// What every lane sends in one pixel slot
	typedef enum logic [1:0] {
		PERIOD_CONTROL  = 2'd0,
		PERIOD_PREAMBLE = 2'd1,
		PERIOD_GUARD    = 2'd2,
		PERIOD_VIDEO    = 2'd3
	} period_t;

endpackage

//--- tmds_pkg.sv
package tmds_pkg;

	//////////////////////////////////////////////////
	// Symbol and bus types
	//////////////////////////////////////////////////

	// One 10-bit TMDS symbol, bit 0 goes out first
	typedef logic [9:0] tmds_word_t;

	// 24-bit pixel, red in the top byte
	typedef struct packed {
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} rgb_t;

	// The three data lanes, ch0 in the low bits
	typedef struct packed {
		tmds_word_t ch2;
		tmds_word_t ch1;
		tmds_word_t ch0;
	} lanes_t;

	// Lane identity, picks guard word and control wiring
	typedef enum logic [1:0] {
		CH_BLUE  = 2'd0,
		CH_GREEN = 2'd1,
		CH_RED   = 2'd2
	} channel_t;

	//////////////////////////////////////////////////
	// Fixed code words
	//////////////////////////////////////////////////

	// Control symbols, indexed by {C1, C0}
	localparam tmds_word_t CTL_CODE [4] = '{
		10'b1101010100,
		10'b0010101011,
		10'b0101010100,
		10'b1010101011
	};

	// Leading video guard band
	localparam tmds_word_t GUARD_BLUE_RED = 10'b1011001100;
	localparam tmds_word_t GUARD_GREEN    = 10'b0100110011;

	// Clock lane, five ones then five zeros on the wire
	localparam tmds_word_t TMDS_CLK_WORD = 10'b0000011111;

	// Bit clocks per pixel slot
	localparam int SER_RATIO = 10;
	localparam int SER_CNT_W = $clog2(SER_RATIO);

endpackage

//--- video_timing_gen.sv
`timescale 1ns/1ps

module video_timing_gen (
	input  logic                     i_clk,
	input  logic                     i_reset,
	input  logic                     i_pix_ce,
	output hdmi_timing_pkg::period_t o_period,
	output logic                     o_hsync,
	output logic                     o_vsync,
	output logic                     o_pix_req
);

	import hdmi_timing_pkg::*;

	// Raster position of the slot being decoded
	logic [H_CNT_W-1:0] h_count;
	logic [V_CNT_W-1:0] v_count;

	// Decode of the current position
	logic    h_last;
	logic    v_last;
	logic    h_active;
	logic    v_active;
	logic    next_line_active;
	logic    in_preamble;
	logic    in_guard;
	logic    hsync_d;
	logic    vsync_d;
	period_t period_d;

	//////////////////////////////////////////////////
	// Position decode
	//////////////////////////////////////////////////

	assign h_last   = (h_count == H_CNT_W'(H_TOTAL - 1));
	assign v_last   = (v_count == V_CNT_W'(V_TOTAL - 1));
	assign h_active = (h_count < H_CNT_W'(H_ACTIVE));
	assign v_active = (v_count < V_CNT_W'(V_ACTIVE));

	// Positive polarity sync windows
	assign hsync_d = (h_count >= H_CNT_W'(H_SYNC_START))
		&& (h_count < H_CNT_W'(H_SYNC_END));
	assign vsync_d = (v_count >= V_CNT_W'(V_SYNC_START))
		&& (v_count < V_CNT_W'(V_SYNC_END));

	// Preamble belongs to the line before active video,
	// so it sits at the tail of the previous line
	assign next_line_active = v_last || (v_count < V_CNT_W'(V_ACTIVE - 1));

	assign in_guard = next_line_active
		&& (h_count >= H_CNT_W'(H_GUARD_START));
	assign in_preamble = next_line_active
		&& (h_count >= H_CNT_W'(H_PREAMBLE_START))
		&& !in_guard;

	always_comb
	begin
		if (h_active && v_active)
			period_d = PERIOD_VIDEO;
		else if (in_guard)
			period_d = PERIOD_GUARD;
		else if (in_preamble)
			period_d = PERIOD_PREAMBLE;
		else
			period_d = PERIOD_CONTROL;
	end

	//////////////////////////////////////////////////
	// Counters and registered outputs
	//////////////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			h_count   <= '0;
			v_count   <= '0;
			o_period  <= PERIOD_CONTROL;
			o_hsync   <= 1'b0;
			o_vsync   <= 1'b0;
			o_pix_req <= 1'b0;
		end
		else if (i_pix_ce)
		begin
			// Outputs hold for the whole slot after the strobe
			o_period  <= period_d;
			o_hsync   <= hsync_d;
			o_vsync   <= vsync_d;
			o_pix_req <= (period_d == PERIOD_VIDEO);

			// Raster scan, wraps at frame end
			if (h_last)
			begin
				h_count <= '0;
				if (v_last)
					v_count <= '0;
				else
					v_count <= v_count + 1'b1;
			end
			else
			begin
				h_count <= h_count + 1'b1;
			end
		end
	end

endmodule

//--- tmds_channel_encoder.sv
`timescale 1ns/1ps

module tmds_channel_encoder #(
	parameter tmds_pkg::channel_t CHANNEL = tmds_pkg::CH_BLUE
) (
	input  logic                     i_clk,
	input  logic                     i_reset,
	input  logic                     i_pix_ce,
	input  hdmi_timing_pkg::period_t i_period,
	input  logic                     i_hsync,
	input  logic                     i_vsync,
	input  logic [7:0]               i_data,
	output tmds_pkg::tmds_word_t     o_word
);

	import hdmi_timing_pkg::*;
	import tmds_pkg::*;

	// Guard word is fixed per lane
	localparam tmds_word_t GUARD_WORD =
		(CHANNEL == CH_GREEN) ? GUARD_GREEN : GUARD_BLUE_RED;

	// Stage 1 inputs
	logic [3:0] data_ones;
	logic       use_xnor;
	logic [8:0] qm_next;
	logic [1:0] ctl_value;

	// Stage 1 registers
	logic [8:0] s1_qm;
	logic [1:0] s1_ctl;
	period_t    s1_period;

	// Stage 2 decode
	logic [3:0]        qm_ones;
	logic signed [4:0] qm_diff;
	tmds_word_t        pix_next;
	logic signed [4:0] disp_next;

	// Stage 2 registers
	tmds_word_t        pix_word;
	tmds_word_t        s2_ctl_word;
	period_t           s2_period;
	logic signed [4:0] disparity;

	//////////////////////////////////////////////////
	// Stage 1, transition minimizing
	//////////////////////////////////////////////////

	always_comb
	begin
		data_ones = '0;
		for (int k = 0; k < 8; k++)
			data_ones = data_ones + 4'(i_data[k]);
	end

	// XNOR chain when the byte is heavy in ones, D[0] breaks the tie
	assign use_xnor = (data_ones > 4'd4) || ((data_ones == 4'd4) && !i_data[0]);

	always_comb
	begin
		qm_next[0] = i_data[0];
		for (int k = 1; k < 8; k++)
			qm_next[k] = use_xnor ? ~(qm_next[k-1] ^ i_data[k])
				: (qm_next[k-1] ^ i_data[k]);
		// Bit 8 tells the decoder which chain was used
		qm_next[8] = ~use_xnor;
	end

	// Control value per lane; only blue carries the syncs
	always_comb
	begin
		case (CHANNEL)
		CH_BLUE:  ctl_value = {i_vsync, i_hsync};
		CH_GREEN: ctl_value = (i_period == PERIOD_PREAMBLE) ? 2'b01 : 2'b00;
		default:  ctl_value = 2'b00;
		endcase
	end

	always_ff @(posedge i_clk)
	begin
		if (i_pix_ce)
			s1_qm <= qm_next;
	end

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			s1_period <= PERIOD_CONTROL;
			s1_ctl    <= 2'b00;
		end
		else if (i_pix_ce)
		begin
			s1_period <= i_period;
			s1_ctl    <= ctl_value;
		end
	end

	//////////////////////////////////////////////////
	// Stage 2, DC balance
	//////////////////////////////////////////////////

	// Ones of q_m itself, not of the input byte
	always_comb
	begin
		qm_ones = '0;
		for (int k = 0; k < 8; k++)
			qm_ones = qm_ones + 4'(s1_qm[k]);
	end

	// Ones minus zeros over q_m[7:0], range -8 to +8
	assign qm_diff = $signed({qm_ones, 1'b0} - 5'd8);

	always_comb
	begin
		pix_next[8] = s1_qm[8];
		if ((disparity == 5'sd0) || (qm_diff == 5'sd0))
		begin
			// Balanced or no history, bit 9 mirrors bit 8
			pix_next[9]   = ~s1_qm[8];
			pix_next[7:0] = s1_qm[8] ? s1_qm[7:0] : ~s1_qm[7:0];
			if (s1_qm[8])
				disp_next = disparity + qm_diff;
			else
				disp_next = disparity - qm_diff;
		end
		else if (((disparity > 5'sd0) && (qm_diff > 5'sd0))
			|| ((disparity < 5'sd0) && (qm_diff < 5'sd0)))
		begin
			// Same sign as the history, so invert
			pix_next[9]   = 1'b1;
			pix_next[7:0] = ~s1_qm[7:0];
			disp_next = disparity - qm_diff + (s1_qm[8] ? 5'sd2 : 5'sd0);
		end
		else
		begin
			pix_next[9]   = 1'b0;
			pix_next[7:0] = s1_qm[7:0];
			disp_next = disparity + qm_diff - (s1_qm[8] ? 5'sd0 : 5'sd2);
		end
	end

	always_ff @(posedge i_clk)
	begin
		if (i_pix_ce && (s1_period == PERIOD_VIDEO))
			pix_word <= pix_next;
	end

	// Disparity only moves on video symbols, holds through blanking
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			disparity   <= 5'sd0;
			s2_period   <= PERIOD_CONTROL;
			s2_ctl_word <= CTL_CODE[0];
		end
		else if (i_pix_ce)
		begin
			s2_period   <= s1_period;
			s2_ctl_word <= CTL_CODE[s1_ctl];
			if (s1_period == PERIOD_VIDEO)
				disparity <= disp_next;
		end
	end

	//////////////////////////////////////////////////
	// Stage 3, symbol select
	//////////////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			o_word <= CTL_CODE[0];
		else if (i_pix_ce)
		begin
			case (s2_period)
			PERIOD_VIDEO: o_word <= pix_word;
			PERIOD_GUARD: o_word <= GUARD_WORD;
			// Preamble is a control period with C0/C1 on green
			default:      o_word <= s2_ctl_word;
			endcase
		end
	end

endmodule

//--- tmds_serializer.sv
`timescale 1ns/1ps

module tmds_serializer (
	input  logic             i_clk,
	input  logic             i_reset,
	input  tmds_pkg::lanes_t i_lanes,
	output logic             o_pix_ce,
	output logic [2:0]       o_tmds_d,
	output logic             o_tmds_clk
);

	import tmds_pkg::*;

	// Bit position within the slot
	logic [SER_CNT_W-1:0] bit_count;

	// Shift registers, bit 0 is on the wire
	lanes_t     sr_lanes;
	tmds_word_t sr_clk;

	//////////////////////////////////////////////////
	// Pixel strobe
	//////////////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			bit_count <= '0;
			o_pix_ce  <= 1'b0;
		end
		else
		begin
			// One pulse per ten bit clocks
			o_pix_ce <= (bit_count == SER_CNT_W'(SER_RATIO - 1));
			if (bit_count == SER_CNT_W'(SER_RATIO - 1))
				bit_count <= '0;
			else
				bit_count <= bit_count + 1'b1;
		end
	end

	//////////////////////////////////////////////////
	// Shift registers, LSB first
	//////////////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			sr_lanes <= '0;
			sr_clk   <= '0;
		end
		else if (o_pix_ce)
		begin
			// Load all four lanes on the same strobe
			sr_lanes <= i_lanes;
			sr_clk   <= TMDS_CLK_WORD;
		end
		else
		begin
			sr_lanes.ch2 <= sr_lanes.ch2 >> 1;
			sr_lanes.ch1 <= sr_lanes.ch1 >> 1;
			sr_lanes.ch0 <= sr_lanes.ch0 >> 1;
			sr_clk       <= sr_clk >> 1;
		end
	end

	assign o_tmds_d   = {sr_lanes.ch2[0], sr_lanes.ch1[0], sr_lanes.ch0[0]};
	assign o_tmds_clk = sr_clk[0];

endmodule

//--- hdmi_tx.sv
`timescale 1ns/1ps

module hdmi_tx (
	input  logic           i_clk,
	input  logic           i_reset,
	input  tmds_pkg::rgb_t i_pixel,
	output logic           o_pix_req,
	output logic [2:0]     o_tmds_d,
	output logic           o_tmds_clk
);

	import hdmi_timing_pkg::*;
	import tmds_pkg::*;

	// Pixel rate strobe from the serializer
	logic    pix_ce;

	// Timing generator outputs
	period_t period;
	logic    hsync;
	logic    vsync;

	// Encoded symbols for the three data lanes
	lanes_t  lanes;

	//////////////////////////////////////////////////
	// Timing
	//////////////////////////////////////////////////

	video_timing_gen u_timing (
		.i_clk     (i_clk),
		.i_reset   (i_reset),
		.i_pix_ce  (pix_ce),
		.o_period  (period),
		.o_hsync   (hsync),
		.o_vsync   (vsync),
		.o_pix_req (o_pix_req)
	);

	//////////////////////////////////////////////////
	// Encoders, blue on ch0
	//////////////////////////////////////////////////

	tmds_channel_encoder #(.CHANNEL(CH_BLUE)) u_enc_blue (
		.i_clk    (i_clk),
		.i_reset  (i_reset),
		.i_pix_ce (pix_ce),
		.i_period (period),
		.i_hsync  (hsync),
		.i_vsync  (vsync),
		.i_data   (i_pixel.blue),
		.o_word   (lanes.ch0)
	);

	tmds_channel_encoder #(.CHANNEL(CH_GREEN)) u_enc_green (
		.i_clk    (i_clk),
		.i_reset  (i_reset),
		.i_pix_ce (pix_ce),
		.i_period (period),
		.i_hsync  (hsync),
		.i_vsync  (vsync),
		.i_data   (i_pixel.green),
		.o_word   (lanes.ch1)
	);

	tmds_channel_encoder #(.CHANNEL(CH_RED)) u_enc_red (
		.i_clk    (i_clk),
		.i_reset  (i_reset),
		.i_pix_ce (pix_ce),
		.i_period (period),
		.i_hsync  (hsync),
		.i_vsync  (vsync),
		.i_data   (i_pixel.red),
		.o_word   (lanes.ch2)
	);

	// Serializer also owns the pixel strobe
	tmds_serializer u_ser (
		.i_clk      (i_clk),
		.i_reset    (i_reset),
		.i_lanes    (lanes),
		.o_pix_ce   (pix_ce),
		.o_tmds_d   (o_tmds_d),
		.o_tmds_clk (o_tmds_clk)
	);

endmodule

//--- hdmi_tx_assert.sv
`timescale 1ns/1ps

module hdmi_tx_assert (
	input logic              i_clk,
	input logic              i_reset,
	input logic              i_pix_ce,
	input logic signed [4:0] i_disparity
);

	// Bit clocks since the last pixel strobe
	logic [3:0] gap;
	// Set once the first strobe after reset went by
	logic       seen_ce;

	//////////////////////////////////////////////////
	// Strobe spacing tracker
	//////////////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			gap     <= '0;
			seen_ce <= 1'b0;
		end
		else if (i_pix_ce)
		begin
			gap     <= '0;
			seen_ce <= 1'b1;
		end
		else if (gap != 4'd15)
			gap <= gap + 4'd1;
	end

	//////////////////////////////////////////////////
	// Properties
	//////////////////////////////////////////////////

	// Strobe exactly ten bit clocks after the previous one
	strobe_spacing: assert property (@(posedge i_clk) disable iff (i_reset)
		(seen_ce && i_pix_ce) |-> (gap == 4'd9))
		else $error("pixel strobe after %0d idle cycles", gap);

	// Never a missing strobe
	strobe_not_late: assert property (@(posedge i_clk) disable iff (i_reset)
		seen_ce |-> (gap <= 4'd9))
		else $error("pixel strobe missing");

	// Running disparity bounded, and even since every symbol is
	disparity_range: assert property (@(posedge i_clk) disable iff (i_reset)
		(i_disparity >= -5'sd8) && (i_disparity <= 5'sd8) && !i_disparity[0])
		else $error("running disparity %0d out of range", i_disparity);

endmodule

//--- tb_hdmi_tx.sv
`timescale 1ns/1ps

module tb_hdmi_tx;

	import hdmi_timing_pkg::*;
	import tmds_pkg::*;

	localparam int CLK_HALF     = 2;
	localparam int RESET_CYCLES = 10;
	// Symbols leaving the encoder pipeline before raster position 0
	localparam int LEAD_IN      = 4;
	localparam int RUN_FRAMES   = 2;
	localparam int RUN_SYMBOLS  = LEAD_IN + RUN_FRAMES * H_TOTAL * V_TOTAL;
	// Three frames of slots at ten bit clocks each, plus slack
	localparam int TIMEOUT_NS   = 3 * H_TOTAL * V_TOTAL * 10 * 2 * CLK_HALF + 2000;

	logic       i_clk;
	logic       i_reset;
	rgb_t       i_pixel = '0;
	logic       o_pix_req;
	logic [2:0] o_tmds_d;
	logic       o_tmds_clk;

	integer     seed;
	rgb_t       pixel_q [$];

	// Model and serial running disparity, one per lane
	int         disp_model [3] = '{0, 0, 0};
	int         disp_serial [3] = '{0, 0, 0};

	// Deserializer state
	logic       aligned = 1'b0;
	int         bit_idx = 0;
	int         zero_run = 0;
	tmds_word_t rx_word [3];
	tmds_word_t rx_clk;

	// Checker raster position and progress
	int         h_pos = 0;
	int         v_pos = 0;
	int         symbols = 0;

	hdmi_tx u_hdmi_tx (
		.i_clk      (i_clk),
		.i_reset    (i_reset),
		.i_pixel    (i_pixel),
		.o_pix_req  (o_pix_req),
		.o_tmds_d   (o_tmds_d),
		.o_tmds_clk (o_tmds_clk)
	);

	bind tmds_channel_encoder hdmi_tx_assert u_assert (
		.i_clk       (i_clk),
		.i_reset     (i_reset),
		.i_pix_ce    (i_pix_ce),
		.i_disparity (disparity)
	);

	//////////////////////////////////////////////////
	// Failure reporting
	//////////////////////////////////////////////////

	task automatic fail_and_stop();
		$display("Some tests failed");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic report_mismatch(input string msg);
		$display("CHECK FAILED at %0t ns: %s", $time, msg);
		fail_and_stop();
	endtask

	task automatic abort_run(input string msg);
		$display("Run aborted: %s", msg);
		fail_and_stop();
	endtask

	//////////////////////////////////////////////////
	// Reference 8b/10b model
	//////////////////////////////////////////////////

	function automatic rgb_t random_pixel();
		logic [31:0] r;
		r = $random(seed);
		return r[23:0];
	endfunction

	// Ones minus zeros of one symbol
	function automatic int word_balance(input tmds_word_t w);
		int n;
		n = 0;
		for (int k = 0; k < 10; k++)
			n += w[k] ? 1 : -1;
		return n;
	endfunction

	function automatic tmds_word_t encode_byte(input logic [7:0] d, input int cnt);
		logic [8:0] qm;
		logic       xnor_chain;
		int         n1_d;
		int         bal;
		tmds_word_t w;
		n1_d = $countones(d);
		xnor_chain = (n1_d > 4) || ((n1_d == 4) && !d[0]);
		qm[0] = d[0];
		for (int k = 1; k < 8; k++)
			qm[k] = xnor_chain ? (qm[k-1] ~^ d[k]) : (qm[k-1] ^ d[k]);
		qm[8] = !xnor_chain;
		bal = 2 * $countones(qm[7:0]) - 8;
		// No history or balanced word, q_m[8] picks polarity
		if ((cnt == 0) || (bal == 0))
			w = {~qm[8], qm[8], qm[8] ? qm[7:0] : ~qm[7:0]};
		else if ((cnt > 0) == (bal > 0))
			w = {1'b1, qm[8], ~qm[7:0]};
		else
			w = {1'b0, qm[8], qm[7:0]};
		return w;
	endfunction

	function automatic logic [7:0] decode_byte(input tmds_word_t w);
		logic [7:0] v;
		logic [7:0] d;
		v = w[9] ? ~w[7:0] : w[7:0];
		d[0] = v[0];
		for (int k = 1; k < 8; k++)
			d[k] = w[8] ? (v[k] ^ v[k-1]) : (v[k] ~^ v[k-1]);
		return d;
	endfunction

	//////////////////////////////////////////////////
	// Per-symbol check
	//////////////////////////////////////////////////

	task automatic check_symbol();
		tmds_word_t exp_word [3];
		logic [7:0] bytes [3];
		logic       hs;
		logic       vs;
		logic       next_active;
		rgb_t       px;
		assert (rx_clk == TMDS_CLK_WORD)
			else report_mismatch($sformatf("clock lane sent %b", rx_clk));
		hs = (h_pos >= H_ACTIVE + H_FRONT) && (h_pos < H_ACTIVE + H_FRONT + H_SYNC);
		vs = (v_pos >= V_ACTIVE + V_FRONT) && (v_pos < V_ACTIVE + V_FRONT + V_SYNC);
		next_active = (((v_pos + 1) % V_TOTAL) < V_ACTIVE);
		exp_word[0] = CTL_CODE[{vs, hs}];
		exp_word[1] = CTL_CODE[0];
		exp_word[2] = CTL_CODE[0];
		if (symbols < LEAD_IN)
			// Reset contents of the pipeline
			exp_word[0] = CTL_CODE[0];
		else if ((h_pos < H_ACTIVE) && (v_pos < V_ACTIVE))
		begin
			assert (pixel_q.size() > 0)
				else abort_run("video symbol arrived with no pixel sent");
			px = pixel_q.pop_front();
			bytes[0] = px.blue;
			bytes[1] = px.green;
			bytes[2] = px.red;
			for (int l = 0; l < 3; l++)
			begin
				exp_word[l] = encode_byte(bytes[l], disp_model[l]);
				disp_model[l] += word_balance(exp_word[l]);
				disp_serial[l] += word_balance(rx_word[l]);
				assert (decode_byte(rx_word[l]) == bytes[l])
					else report_mismatch($sformatf("lane %0d decodes to %h, sent %h",
						l, decode_byte(rx_word[l]), bytes[l]));
				assert ((disp_serial[l] <= 8) && (disp_serial[l] >= -8))
					else report_mismatch($sformatf("lane %0d disparity %0d",
						l, disp_serial[l]));
				assert (disp_serial[l] == disp_model[l])
					else report_mismatch($sformatf("lane %0d serial disparity %0d, model %0d",
						l, disp_serial[l], disp_model[l]));
			end
		end
		else if (next_active && (h_pos >= H_TOTAL - GUARD_LEN))
		begin
			exp_word[0] = GUARD_BLUE_RED;
			exp_word[1] = GUARD_GREEN;
			exp_word[2] = GUARD_BLUE_RED;
		end
		else if (next_active && (h_pos >= H_TOTAL - GUARD_LEN - PREAMBLE_LEN))
			exp_word[1] = CTL_CODE[1];
		for (int l = 0; l < 3; l++)
			assert (rx_word[l] == exp_word[l])
				else report_mismatch($sformatf("lane %0d at h %0d v %0d got %b, expected %b",
					l, h_pos, v_pos, rx_word[l], exp_word[l]));
		// Raster advances only once the lead-in is out
		if (symbols >= LEAD_IN)
		begin
			if (h_pos == H_TOTAL - 1)
			begin
				h_pos = 0;
				v_pos = (v_pos == V_TOTAL - 1) ? 0 : v_pos + 1;
			end
			else
				h_pos++;
		end
		symbols++;
	endtask

	//////////////////////////////////////////////////
	// Clock, reset, stimulus
	//////////////////////////////////////////////////

	initial
	begin
		i_clk = 1'b0;
		forever #(CLK_HALF) i_clk = ~i_clk;
	end

	// Pixel consumed on a strobe with a request, next one follows at once
	always @(posedge i_clk)
	begin
		if (i_reset)
			i_pixel <= random_pixel();
		else if (u_hdmi_tx.pix_ce && o_pix_req)
		begin
			pixel_q.push_back(i_pixel);
			i_pixel <= random_pixel();
		end
	end

	// Deserializer, mid-cycle sampling
	always @(negedge i_clk)
	begin
		if (i_reset)
		begin
			aligned  = 1'b0;
			bit_idx  = 0;
			zero_run = 0;
		end
		else
		begin
			// Slot starts where the clock lane rises after five zeros
			if (!aligned && o_tmds_clk && (zero_run >= 5))
				aligned = 1'b1;
			if (aligned)
			begin
				rx_clk[bit_idx] = o_tmds_clk;
				for (int l = 0; l < 3; l++)
					rx_word[l][bit_idx] = o_tmds_d[l];
				bit_idx++;
				if (bit_idx == 10)
				begin
					check_symbol();
					bit_idx = 0;
				end
			end
			else
				zero_run = o_tmds_clk ? 0 : zero_run + 1;
		end
	end

	initial
	begin
		seed = 38728;
		i_reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge i_clk);
		i_reset <= 1'b0;
		wait (symbols >= RUN_SYMBOLS);
		// First slots of the next frame are requested but still in the pipeline
		@(negedge i_clk);
		if (pixel_q.size() == LEAD_IN)
		begin
			$display("All tests passed");
			$finish;
		end
		else
			report_mismatch($sformatf("%0d pixels requested ahead of the wire, expected %0d",
				pixel_q.size(), LEAD_IN));
	end

	// Watchdog
	initial
	begin
		#(TIMEOUT_NS);
		abort_run("watchdog expired before all symbols were checked");
	end

endmodule

//--- verilog.f
hdmi_timing_pkg.sv
tmds_pkg.sv
video_timing_gen.sv
tmds_channel_encoder.sv
tmds_serializer.sv
hdmi_tx.sv
hdmi_tx_assert.sv
tb_hdmi_tx.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = tb_hdmi_tx
FILELIST  = verilog.f
OBJ_DIR   = obj_dir
SIM_BIN   = $(OBJ_DIR)/V$(TOP)
PASS_MSG  = All tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the simulation output holds the pass message
run: compile
	@out="$$(./$(SIM_BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
